//--- Makefile
# Verilator build and run of the receive PCS testbench
LOG := sim.log

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -j 0 --top-module tb_eth_rx_pcs -f verilog.f

run: compile
	./obj_dir/Vtb_eth_rx_pcs > $(LOG) 2>&1; cat $(LOG)
	grep -q "^TESTBENCH PASSED$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- common/pcs_pkg.sv
// Constants for a 10GBASE-R receive PCS, only all-idle, start-0 and terminate-0 control blocks
package pcs_pkg;

    // Block and XGMII widths
    localparam int data_width = 64;
    localparam int hdr_width  = 2;
    localparam int ctrl_width = 8;

    // Sync header codes
    localparam logic [1:0] hdr_data = 2'b01;
    localparam logic [1:0] hdr_ctrl = 2'b10;

    // Supported control block types
    localparam logic [7:0] blk_idle   = 8'h1e;
    localparam logic [7:0] blk_start0 = 8'h78;
    localparam logic [7:0] blk_term0  = 8'h87;

    // XGMII lane characters
    localparam logic [7:0] xgmii_idle  = 8'h07;
    localparam logic [7:0] xgmii_start = 8'hfb;
    localparam logic [7:0] xgmii_term  = 8'hfd;
    localparam logic [7:0] xgmii_error = 8'hfe;

    // Block lock thresholds
    localparam logic [6:0] lock_good_count  = 7'd64;
    localparam logic [4:0] unlock_bad_limit = 5'd16;
    localparam logic [6:0] lock_window      = 7'd64;
    localparam logic [2:0] slip_holdoff     = 3'd4;

    // Descrambler for 1 + x^39 + x^58
    localparam logic [5:0] scr_len = 6'd58;
    localparam int         scr_tap = 39;

    // Status registers
    localparam int          cnt_width   = 16;
    localparam logic [11:0] reg_status  = 12'h000;
    localparam logic [11:0] reg_hdr_err = 12'h004;
    localparam logic [11:0] reg_dec_err = 12'h008;

endpackage

//--- dv/eth_rx_pcs_asserts.sv
// Bound to the PCS top level; every property is disabled while reset is high
`timescale 1ns/10ps

module eth_rx_pcs_asserts (
    input logic       gt_rxusrclk,
    input logic       gt_tx_reset,
    input logic [1:0] serdes_rx_hdr,
    input logic       serdes_rx_bitslip,
    input logic       block_lock,
    input logic       psel,
    input logic       penable,
    input logic       pslverr
);

    // Four quiet blocks after every slip
    assert property (@(posedge gt_rxusrclk) disable iff (gt_tx_reset)
        serdes_rx_bitslip |-> !$past(serdes_rx_bitslip, 1) && !$past(serdes_rx_bitslip, 2) &&
                              !$past(serdes_rx_bitslip, 3) && !$past(serdes_rx_bitslip, 4))
        else $error("Slip requests closer than the hold-off");

    assert property (@(posedge gt_rxusrclk) disable iff (gt_tx_reset)
        serdes_rx_bitslip |-> !block_lock)
        else $error("Slip request while locked");

    // Lock only rises on a good header and only falls on a bad one
    assert property (@(posedge gt_rxusrclk) disable iff (gt_tx_reset)
        $rose(block_lock) |-> $past(serdes_rx_hdr) == pcs_pkg::hdr_data ||
                              $past(serdes_rx_hdr) == pcs_pkg::hdr_ctrl)
        else $error("Lock rose on an invalid header");

    assert property (@(posedge gt_rxusrclk) disable iff (gt_tx_reset)
        $fell(block_lock) |-> $past(serdes_rx_hdr) != pcs_pkg::hdr_data &&
                              $past(serdes_rx_hdr) != pcs_pkg::hdr_ctrl)
        else $error("Lock fell on a valid header");

    assert property (@(posedge gt_rxusrclk) disable iff (gt_tx_reset)
        pslverr |-> psel && penable)
        else $error("APB error response outside an access cycle");

endmodule

//--- dv/tb_eth_rx_pcs.sv
// Fixed-seed random traffic; the lock loss test assumes each 64-block window starts at lock
`timescale 1ns/10ps

module tb_eth_rx_pcs;

    localparam int max_cycles = 4000;

    logic        gt_rxusrclk;
    logic        gt_tx_reset;
    logic [63:0] serdes_rx_data;
    logic [1:0]  serdes_rx_hdr;
    logic        serdes_rx_bitslip;
    logic [63:0] xgmii_rxd;
    logic [7:0]  xgmii_rxc;
    logic [11:0] paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    // Reference model state
    logic [71:0] exp_q[$];
    logic [57:0] scr_hist;
    logic        model_lock;
    int          slip_cnt;
    int          locked_blocks;
    int          bad_budget;
    int          cnt_hdr;
    int          cnt_dec;
    int          n_checks;
    int          n_errors;
    int          cycle_cnt;
    logic [31:0] rd_data;
    logic        rd_err;

    eth_rx_pcs i_dut (
        .gt_rxusrclk       (gt_rxusrclk),
        .gt_tx_reset       (gt_tx_reset),
        .serdes_rx_data    (serdes_rx_data),
        .serdes_rx_hdr     (serdes_rx_hdr),
        .serdes_rx_bitslip (serdes_rx_bitslip),
        .xgmii_rxd         (xgmii_rxd),
        .xgmii_rxc         (xgmii_rxc),
        .paddr             (paddr),
        .psel              (psel),
        .penable           (penable),
        .pwrite            (pwrite),
        .pwdata            (pwdata),
        .prdata            (prdata),
        .pready            (pready),
        .pslverr           (pslverr)
    );

    bind eth_rx_pcs eth_rx_pcs_asserts i_asserts (
        .gt_rxusrclk       (gt_rxusrclk),
        .gt_tx_reset       (gt_tx_reset),
        .serdes_rx_hdr     (serdes_rx_hdr),
        .serdes_rx_bitslip (serdes_rx_bitslip),
        .block_lock        (block_lock),
        .psel              (psel),
        .penable           (penable),
        .pslverr           (pslverr)
    );

    initial begin
        gt_rxusrclk = 1'b0;
        forever #10 gt_rxusrclk = ~gt_rxusrclk;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < max_cycles) begin
            @(posedge gt_rxusrclk);
            cycle_cnt++;
        end
        $display("Timeout: the run did not finish within %0d cycles", max_cycles);
        $display("Checks: %0d, errors: %0d", n_checks, n_errors);
        $display("TESTBENCH FAILED");
        $finish;
    end

    // Expected {bad, rxc, rxd} of one block
    function automatic logic [72:0] decode_ref(input logic [1:0] hdr, input logic [63:0] plain,
                                               input logic locked);
        logic [63:0] rxd;
        logic [7:0]  rxc;
        logic        bad;
        rxd = plain;
        rxc = 8'h00;
        bad = 1'b0;
        if (hdr == pcs_pkg::hdr_ctrl && plain[7:0] == pcs_pkg::blk_idle) begin
            rxd = {8{pcs_pkg::xgmii_idle}};
            rxc = 8'hff;
        end else if (hdr == pcs_pkg::hdr_ctrl && plain[7:0] == pcs_pkg::blk_start0) begin
            rxd = {plain[63:8], pcs_pkg::xgmii_start};
            rxc = 8'h01;
        end else if (hdr == pcs_pkg::hdr_ctrl && plain[7:0] == pcs_pkg::blk_term0) begin
            rxd = {{7{pcs_pkg::xgmii_idle}}, pcs_pkg::xgmii_term};
            rxc = 8'hff;
        end else if (hdr != pcs_pkg::hdr_data) begin
            bad = 1'b1;
        end
        if (!locked || bad) begin
            rxd = {8{pcs_pkg::xgmii_error}};
            rxc = 8'hff;
        end
        return {bad, rxc, rxd};
    endfunction

    task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] got);
        n_checks++;
        assert (got === exp) else begin
            n_errors++;
            $display("FAIL time=%0t signal=%s expected=%h actual=%h", $time, name, exp, got);
        end
    endtask

    // One block per cycle; lock_after is the lock state expected once this block is taken
    task automatic send_block(input logic [1:0] hdr, input logic [63:0] plain,
                              input logic lock_after);
        logic [72:0]  exp;
        logic [71:0]  old;
        logic [121:0] s;
        logic         lock_before;
        exp = decode_ref(hdr, plain, lock_after);
        if (model_lock && hdr != pcs_pkg::hdr_data && hdr != pcs_pkg::hdr_ctrl) begin
            cnt_hdr++;
        end
        if (lock_after && exp[72]) begin
            cnt_dec++;
        end
        if (model_lock) begin
            locked_blocks++;
        end
        // Scrambler 1 + x^39 + x^58 over the continuous stream, oldest bit first
        s = {64'b0, scr_hist};
        for (int i = 0; i < 64; i++) begin
            s[58 + i] = plain[i] ^ s[19 + i] ^ s[i];
        end
        scr_hist       = s[121:64];
        serdes_rx_hdr  = hdr;
        serdes_rx_data = s[121:58];
        exp_q.push_back(exp[71:0]);
        lock_before = model_lock;
        model_lock  = lock_after;
        @(negedge gt_rxusrclk);
        if (serdes_rx_bitslip) begin
            slip_cnt++;
        end
        if (lock_before) begin
            n_checks++;
            assert (!serdes_rx_bitslip) else begin
                n_errors++;
                $display("Slip request raised while the block lock was held");
            end
        end
        check_val("block_lock", {63'b0, model_lock}, {63'b0, i_dut.block_lock});
        // Output now shows the block sent two calls earlier
        if (exp_q.size() == 3) begin
            old = exp_q.pop_front();
            check_val("xgmii_rxd", old[63:0], xgmii_rxd);
            check_val("xgmii_rxc", {56'b0, old[71:64]}, {56'b0, xgmii_rxc});
        end
    endtask

    task automatic send_idle();
        send_block(pcs_pkg::hdr_ctrl, {56'b0, pcs_pkg::blk_idle}, model_lock);
    endtask

    task automatic send_random(input logic inject);
        int          kind;
        logic [63:0] payload;
        logic [7:0]  btype;
        payload = {$urandom, $urandom};
        kind    = $urandom_range(0, 9);
        btype   = 8'($urandom);
        if (btype == pcs_pkg::blk_idle || btype == pcs_pkg::blk_start0 ||
            btype == pcs_pkg::blk_term0) begin
            btype = 8'h00;
        end
        if (kind <= 4 || (kind == 9 && !inject)) begin
            send_block(pcs_pkg::hdr_data, payload, 1'b1);
        end else if (kind <= 6) begin
            send_block(pcs_pkg::hdr_ctrl, {56'b0, pcs_pkg::blk_idle}, 1'b1);
        end else if (kind == 7) begin
            send_block(pcs_pkg::hdr_ctrl, {payload[63:8], pcs_pkg::blk_start0}, 1'b1);
        end else if (kind == 8) begin
            send_block(pcs_pkg::hdr_ctrl, {payload[63:8], pcs_pkg::blk_term0}, 1'b1);
        end else if (bad_budget > 0 && payload[0]) begin
            // Invalid header, kept well under the unlock limit
            bad_budget--;
            send_block(payload[1] ? 2'b00 : 2'b11, payload, 1'b1);
        end else begin
            send_block(pcs_pkg::hdr_ctrl, {payload[63:8], btype}, 1'b1);
        end
    endtask

    task automatic apb_access(input logic write, input logic [11:0] addr,
                              output logic [31:0] rdata, output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = $urandom;
        send_idle();
        penable = 1'b1;
        rdata   = prdata;
        err     = pslverr;
        n_checks++;
        assert (pready) else begin
            n_errors++;
            $display("APB pready was low in the access cycle");
        end
        send_idle();
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic read_expect(input logic [11:0] addr, input logic [31:0] exp, input string name);
        logic [31:0] data;
        logic        err;
        apb_access(1'b0, addr, data, err);
        check_val(name, {32'b0, exp}, {32'b0, data});
        check_val("pslverr", 64'd0, {63'b0, err});
    endtask

    task automatic write_reg(input logic [11:0] addr);
        logic [31:0] data;
        logic        err;
        apb_access(1'b1, addr, data, err);
        check_val("pslverr", 64'd0, {63'b0, err});
    endtask

    initial begin
        void'($urandom(97944));
        gt_tx_reset    = 1'b1;
        serdes_rx_data = '0;
        serdes_rx_hdr  = '0;
        paddr          = '0;
        psel           = 1'b0;
        penable        = 1'b0;
        pwrite         = 1'b0;
        pwdata         = '0;
        scr_hist       = '0;
        model_lock     = 1'b0;
        slip_cnt       = 0;
        locked_blocks  = 0;
        bad_budget     = 12;
        cnt_hdr        = 0;
        cnt_dec        = 0;
        n_checks       = 0;
        n_errors       = 0;
        repeat (8) @(negedge gt_rxusrclk);
        gt_tx_reset = 1'b0;

        // Hunting on bad headers, then lock on the 64th good one
        while (slip_cnt < 3) begin
            send_block(2'b00, {$urandom, $urandom}, 1'b0);
        end
        for (int i = 1; i <= 64; i++) begin
            send_block(pcs_pkg::hdr_data, {$urandom, $urandom}, i == 64);
        end

        repeat (800) send_random(1'b0);

        // Error injection, then counters over APB
        repeat (500) send_random(1'b1);
        repeat (6) send_idle();
        read_expect(pcs_pkg::reg_hdr_err, 32'(cnt_hdr), "hdr_err_cnt");
        read_expect(pcs_pkg::reg_dec_err, 32'(cnt_dec), "dec_err_cnt");
        read_expect(pcs_pkg::reg_status, {31'b0, model_lock}, "status");
        // Status write must leave lock and both counters alone
        write_reg(pcs_pkg::reg_status);
        read_expect(pcs_pkg::reg_status, {31'b0, model_lock}, "status");
        read_expect(pcs_pkg::reg_hdr_err, 32'(cnt_hdr), "hdr_err_cnt");
        read_expect(pcs_pkg::reg_dec_err, 32'(cnt_dec), "dec_err_cnt");
        write_reg(pcs_pkg::reg_hdr_err);
        cnt_hdr = 0;
        write_reg(pcs_pkg::reg_dec_err);
        cnt_dec = 0;
        read_expect(pcs_pkg::reg_hdr_err, 32'(cnt_hdr), "hdr_err_cnt");
        read_expect(pcs_pkg::reg_dec_err, 32'(cnt_dec), "dec_err_cnt");
        apb_access(1'b0, 12'h00c, rd_data, rd_err);
        check_val("pslverr", 64'd1, {63'b0, rd_err});

        // Sixteen bad headers from the start of a window
        while (locked_blocks % 64 != 0) begin
            send_idle();
        end
        for (int i = 1; i <= 16; i++) begin
            send_block(2'b11, {$urandom, $urandom}, i < 16);
        end
        repeat (4) send_idle();
        read_expect(pcs_pkg::reg_status, {31'b0, model_lock}, "status");
        read_expect(pcs_pkg::reg_hdr_err, 32'(cnt_hdr), "hdr_err_cnt");
        read_expect(pcs_pkg::reg_dec_err, 32'(cnt_dec), "dec_err_cnt");
        repeat (3) send_idle();

        $display("Checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- logic/eth_rx_pcs.sv
// Single clock domain, a block is expected every cycle and XGMII has no back-pressure
`timescale 1ns/10ps

module eth_rx_pcs (
    input  logic                           gt_rxusrclk,
    input  logic                           gt_tx_reset,
    input  logic [pcs_pkg::data_width-1:0] serdes_rx_data,
    input  logic [pcs_pkg::hdr_width-1:0]  serdes_rx_hdr,
    output logic                           serdes_rx_bitslip,
    output logic [pcs_pkg::data_width-1:0] xgmii_rxd,
    output logic [pcs_pkg::ctrl_width-1:0] xgmii_rxc,
    input  logic [11:0]                    paddr,
    input  logic                           psel,
    input  logic                           penable,
    input  logic                           pwrite,
    input  logic [31:0]                    pwdata,
    output logic [31:0]                    prdata,
    output logic                           pready,
    output logic                           pslverr
);

    logic [pcs_pkg::data_width-1:0] lock_data;
    logic [pcs_pkg::hdr_width-1:0]  lock_hdr;
    logic                           block_lock;
    logic                           hdr_err;
    logic [pcs_pkg::data_width-1:0] descr_data;
    logic [pcs_pkg::hdr_width-1:0]  descr_hdr;
    logic                           descr_lock;
    logic                           dec_err;

    // Header alignment and lock
    rx_block_lock i_block_lock (
        .gt_rxusrclk       (gt_rxusrclk),
        .gt_tx_reset       (gt_tx_reset),
        .serdes_rx_data    (serdes_rx_data),
        .serdes_rx_hdr     (serdes_rx_hdr),
        .serdes_rx_bitslip (serdes_rx_bitslip),
        .lock_data         (lock_data),
        .lock_hdr          (lock_hdr),
        .block_lock        (block_lock),
        .hdr_err           (hdr_err)
    );

    rx_descrambler i_descrambler (
        .gt_rxusrclk (gt_rxusrclk),
        .gt_tx_reset (gt_tx_reset),
        .lock_data   (lock_data),
        .lock_hdr    (lock_hdr),
        .block_lock  (block_lock),
        .descr_data  (descr_data),
        .descr_hdr   (descr_hdr),
        .descr_lock  (descr_lock)
    );

    rx_block_decode i_block_decode (
        .gt_rxusrclk (gt_rxusrclk),
        .gt_tx_reset (gt_tx_reset),
        .descr_data  (descr_data),
        .descr_hdr   (descr_hdr),
        .descr_lock  (descr_lock),
        .xgmii_rxd   (xgmii_rxd),
        .xgmii_rxc   (xgmii_rxc),
        .dec_err     (dec_err)
    );

    // Status and error counters
    pcs_status_apb i_status (
        .gt_rxusrclk (gt_rxusrclk),
        .gt_tx_reset (gt_tx_reset),
        .paddr       (paddr),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .block_lock  (block_lock),
        .hdr_err     (hdr_err),
        .dec_err     (dec_err)
    );

endmodule

//--- logic/pcs_status_apb.sv
// Zero wait states; counter reads are sampled in the setup cycle and writes only clear
`timescale 1ns/10ps

module pcs_status_apb (
    input  logic        gt_rxusrclk,
    input  logic        gt_tx_reset,
    input  logic [11:0] paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    input  logic        block_lock,
    input  logic        hdr_err,
    input  logic        dec_err
);

    logic                          setup_phase;
    logic                          wr_access;
    logic                          addr_hit;
    logic [31:0]                   rd_mux;
    logic [pcs_pkg::cnt_width-1:0] hdr_err_cnt;
    logic [pcs_pkg::cnt_width-1:0] dec_err_cnt;

    // Clear wins over a coincident increment
    function automatic logic [pcs_pkg::cnt_width-1:0] cnt_next(
        input logic [pcs_pkg::cnt_width-1:0] cnt,
        input logic                          inc,
        input logic                          clr
    );
        if (clr) begin
            return '0;
        end
        if (inc && cnt != '1) begin
            return cnt + 1'b1;
        end
        return cnt;
    endfunction

    assign pready      = 1'b1;
    assign setup_phase = psel && !penable;
    assign wr_access   = psel && penable && pwrite;

    always_comb begin
        addr_hit = 1'b1;
        rd_mux   = '0;
        case (paddr)
            pcs_pkg::reg_status:  rd_mux = {31'b0, block_lock};
            pcs_pkg::reg_hdr_err: rd_mux = {{(32-pcs_pkg::cnt_width){1'b0}}, hdr_err_cnt};
            pcs_pkg::reg_dec_err: rd_mux = {{(32-pcs_pkg::cnt_width){1'b0}}, dec_err_cnt};
            default:              addr_hit = 1'b0;
        endcase
    end

    always_ff @(posedge gt_rxusrclk or posedge gt_tx_reset) begin
        if (gt_tx_reset) begin
            hdr_err_cnt <= '0;
            dec_err_cnt <= '0;
            prdata      <= '0;
            pslverr     <= 1'b0;
        end else begin
            hdr_err_cnt <= cnt_next(hdr_err_cnt, hdr_err,
                                    wr_access && paddr == pcs_pkg::reg_hdr_err);
            dec_err_cnt <= cnt_next(dec_err_cnt, dec_err,
                                    wr_access && paddr == pcs_pkg::reg_dec_err);
            // Response is set up one cycle early so it is valid in the access cycle
            if (setup_phase) begin
                prdata  <= pwrite ? '0 : rd_mux;
                pslverr <= !addr_hit;
            end else begin
                prdata  <= '0;
                pslverr <= 1'b0;
            end
        end
    end

endmodule

//--- rx_pcs/rx_block_decode.sv
// Decodes only all-idle, start-0 and terminate-0 control blocks; all others become error lanes
`timescale 1ns/10ps

module rx_block_decode (
    input  logic                           gt_rxusrclk,
    input  logic                           gt_tx_reset,
    input  logic [pcs_pkg::data_width-1:0] descr_data,
    input  logic [pcs_pkg::hdr_width-1:0]  descr_hdr,
    input  logic                           descr_lock,
    output logic [pcs_pkg::data_width-1:0] xgmii_rxd,
    output logic [pcs_pkg::ctrl_width-1:0] xgmii_rxc,
    output logic                           dec_err
);

    logic [7:0]                     blk_type;
    logic [pcs_pkg::data_width-1:0] rxd_next;
    logic [pcs_pkg::ctrl_width-1:0] rxc_next;
    logic                           blk_bad;

    assign blk_type = descr_data[7:0];

    always_comb begin
        rxd_next = {pcs_pkg::ctrl_width{pcs_pkg::xgmii_error}};
        rxc_next = '1;
        blk_bad  = 1'b1;
        if (descr_lock) begin
            if (descr_hdr == pcs_pkg::hdr_data) begin
                rxd_next = descr_data;
                rxc_next = '0;
                blk_bad  = 1'b0;
            end else if (descr_hdr == pcs_pkg::hdr_ctrl) begin
                case (blk_type)
                    pcs_pkg::blk_idle: begin
                        rxd_next = {pcs_pkg::ctrl_width{pcs_pkg::xgmii_idle}};
                        blk_bad  = 1'b0;
                    end
                    pcs_pkg::blk_start0: begin
                        // Bytes 1 to 7 carry frame data
                        rxd_next = {descr_data[pcs_pkg::data_width-1:8], pcs_pkg::xgmii_start};
                        rxc_next = 8'h01;
                        blk_bad  = 1'b0;
                    end
                    pcs_pkg::blk_term0: begin
                        rxd_next = {{(pcs_pkg::ctrl_width-1){pcs_pkg::xgmii_idle}},
                                    pcs_pkg::xgmii_term};
                        blk_bad  = 1'b0;
                    end
                    default: begin
                        blk_bad = 1'b1;
                    end
                endcase
            end
        end
    end

    // Invalid headers also count as decode errors while locked
    always_ff @(posedge gt_rxusrclk or posedge gt_tx_reset) begin
        if (gt_tx_reset) begin
            xgmii_rxd <= {pcs_pkg::ctrl_width{pcs_pkg::xgmii_error}};
            xgmii_rxc <= '1;
            dec_err   <= 1'b0;
        end else begin
            xgmii_rxd <= rxd_next;
            xgmii_rxc <= rxc_next;
            dec_err   <= descr_lock && blk_bad;
        end
    end

endmodule

//--- rx_pcs/rx_block_lock.sv
// Expects one 66-bit block per cycle with no data-valid gaps; slips act on the next block
`timescale 1ns/10ps

module rx_block_lock (
    input  logic                           gt_rxusrclk,
    input  logic                           gt_tx_reset,
    input  logic [pcs_pkg::data_width-1:0] serdes_rx_data,
    input  logic [pcs_pkg::hdr_width-1:0]  serdes_rx_hdr,
    output logic                           serdes_rx_bitslip,
    output logic [pcs_pkg::data_width-1:0] lock_data,
    output logic [pcs_pkg::hdr_width-1:0]  lock_hdr,
    output logic                           block_lock,
    output logic                           hdr_err
);

    logic                                        hdr_valid;
    logic [$bits(pcs_pkg::lock_good_count)-1:0]  good_cnt;
    logic [$bits(pcs_pkg::unlock_bad_limit)-1:0] bad_cnt;
    logic [$bits(pcs_pkg::lock_window)-1:0]      win_cnt;
    logic [$bits(pcs_pkg::slip_holdoff)-1:0]     holdoff_cnt;

    assign hdr_valid = (serdes_rx_hdr == pcs_pkg::hdr_data) ||
                       (serdes_rx_hdr == pcs_pkg::hdr_ctrl);

    // Block register, lock state below lines up with it
    always_ff @(posedge gt_rxusrclk) begin
        lock_data <= serdes_rx_data;
        lock_hdr  <= serdes_rx_hdr;
    end

    always_ff @(posedge gt_rxusrclk or posedge gt_tx_reset) begin
        if (gt_tx_reset) begin
            serdes_rx_bitslip <= 1'b0;
            block_lock        <= 1'b0;
            hdr_err           <= 1'b0;
            good_cnt          <= '0;
            bad_cnt           <= '0;
            win_cnt           <= '0;
            holdoff_cnt       <= '0;
        end else begin
            serdes_rx_bitslip <= 1'b0;
            hdr_err           <= 1'b0;
            if (holdoff_cnt != '0) begin
                holdoff_cnt <= holdoff_cnt - 1'b1;
            end
            if (!block_lock) begin
                // Hunting, valid headers still count during the hold-off
                if (hdr_valid) begin
                    if (good_cnt == pcs_pkg::lock_good_count - 1'b1) begin
                        block_lock <= 1'b1;
                        good_cnt   <= '0;
                        bad_cnt    <= '0;
                        win_cnt    <= '0;
                    end else begin
                        good_cnt <= good_cnt + 1'b1;
                    end
                end else begin
                    good_cnt <= '0;
                    if (holdoff_cnt == '0) begin
                        serdes_rx_bitslip <= 1'b1;
                        holdoff_cnt       <= pcs_pkg::slip_holdoff;
                    end
                end
            end else begin
                hdr_err <= !hdr_valid;
                if (!hdr_valid && bad_cnt == pcs_pkg::unlock_bad_limit - 1'b1) begin
                    // Too many bad headers in this window
                    block_lock <= 1'b0;
                    bad_cnt    <= '0;
                    win_cnt    <= '0;
                end else if (win_cnt == pcs_pkg::lock_window - 1'b1) begin
                    win_cnt <= '0;
                    bad_cnt <= '0;
                end else begin
                    win_cnt <= win_cnt + 1'b1;
                    if (!hdr_valid) begin
                        bad_cnt <= bad_cnt + 1'b1;
                    end
                end
            end
        end
    end

endmodule

//--- rx_pcs/rx_descrambler.sv
// Output of the first block after reset is unknown until the history has filled once
`timescale 1ns/10ps

module rx_descrambler (
    input  logic                           gt_rxusrclk,
    input  logic                           gt_tx_reset,
    input  logic [pcs_pkg::data_width-1:0] lock_data,
    input  logic [pcs_pkg::hdr_width-1:0]  lock_hdr,
    input  logic                           block_lock,
    output logic [pcs_pkg::data_width-1:0] descr_data,
    output logic [pcs_pkg::hdr_width-1:0]  descr_hdr,
    output logic                           descr_lock
);

    // Oldest received bit sits in bit 0
    logic [pcs_pkg::scr_len-1:0]                    scr_state;
    logic [pcs_pkg::data_width+pcs_pkg::scr_len-1:0] bit_stream;
    logic [pcs_pkg::data_width-1:0]                 plain;

    assign bit_stream = {lock_data, scr_state};

    // Input bit i sits at scr_len + i in the stream
    always_comb begin
        for (int i = 0; i < pcs_pkg::data_width; i++) begin
            plain[i] = bit_stream[pcs_pkg::scr_len + i] ^
                       bit_stream[pcs_pkg::scr_len + i - pcs_pkg::scr_tap] ^
                       bit_stream[i];
        end
    end

    always_ff @(posedge gt_rxusrclk) begin
        scr_state  <= lock_data[pcs_pkg::data_width-1 -: pcs_pkg::scr_len];
        descr_data <= plain;
        descr_hdr  <= lock_hdr;
    end

    always_ff @(posedge gt_rxusrclk or posedge gt_tx_reset) begin
        if (gt_tx_reset) begin
            descr_lock <= 1'b0;
        end else begin
            descr_lock <= block_lock;
        end
    end

endmodule

//--- verilog.f
common/pcs_pkg.sv
rx_pcs/rx_block_lock.sv
rx_pcs/rx_descrambler.sv
rx_pcs/rx_block_decode.sv
logic/pcs_status_apb.sv
logic/eth_rx_pcs.sv
dv/eth_rx_pcs_asserts.sv
dv/tb_eth_rx_pcs.sv
